//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] boot_address = '0;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        st_fetch,
        st_decode,
        st_execute_alu,
        st_execute_imm,
        st_execute_branch,
        st_execute_jal,
        st_execute_jalr,
        st_execute_lui,
        st_execute_auipc,
        st_mem_addr,
        st_mem_read,
        st_mem_write,
        st_load_writeback,
        st_alu_writeback
    } state_e;

    typedef enum logic [1:0] {
        mode_add,
        mode_branch,
        mode_reg,
        mode_imm
    } alu_mode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        src_a_pc,
        src_a_rs1,
        src_a_old_pc,
        src_a_zero
    } src_a_e;

    typedef enum logic [1:0] {
        src_b_rs2,
        src_b_four,
        src_b_imm
    } src_b_e;

    typedef enum logic {
        wb_alu,
        wb_mem
    } wb_src_e;

    typedef struct packed {
        logic      pc_write;
        logic      pc_write_cond;
        logic      branch_on_ne;      // Polarity taken from funct3 bit 0
        logic      addr_from_alu;
        logic      mem_read;
        logic      mem_write;
        logic      ir_write;
        logic      reg_write;
        logic      pc_from_alu_reg;
        alu_mode_e alu_mode;
        src_a_e    src_a;
        src_b_e    src_b;
        wb_src_e   wb_src;
    } ctrl_t;

    typedef struct packed {
        logic            read;
        logic            write;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import core_pkg::*;
(
    input  alu_mode_e       mode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [xlen-1:0] in_a,
    input  logic [xlen-1:0] in_b,
    output logic [xlen-1:0] result,
    output logic            zero
);

    alu_op_e op;
    logic    alt;

    assign alt = funct7[5];

    always_comb begin
        op = alu_pass_b;
        case (mode)
            mode_add:    op = alu_add;
            mode_branch: op = alu_sub;                     // Equality through the zero flag
            mode_reg, mode_imm: begin
                case (funct3)
                    3'b000:  op = (mode == mode_reg && alt) ? alu_sub : alu_add;
                    3'b001:  op = alu_sll;
                    3'b010:  op = alu_slt;
                    3'b011:  op = alu_sltu;
                    3'b100:  op = alu_xor;
                    3'b101:  op = alt ? alu_sra : alu_srl;  // SRAI carries it in imm[10]
                    3'b110:  op = alu_or;
                    default: op = alu_and;
                endcase
            end
            default: op = alu_pass_b;
        endcase
    end

    always_comb begin
        case (op)
            alu_add:  result = in_a + in_b;
            alu_sub:  result = in_a - in_b;
            alu_sll:  result = in_a << in_b[4:0];
            alu_slt:  result = {{(xlen - 1){1'b0}}, $signed(in_a) < $signed(in_b)};
            alu_sltu: result = {{(xlen - 1){1'b0}}, in_a < in_b};
            alu_xor:  result = in_a ^ in_b;
            alu_srl:  result = in_a >> in_b[4:0];
            alu_sra:  result = $signed(in_a) >>> in_b[4:0];
            alu_or:   result = in_a | in_b;
            alu_and:  result = in_a & in_b;
            default:  result = in_b;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- logic/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import core_pkg::*;
(
    input  logic [xlen-1:0] instruction,
    output logic [xlen-1:0] immediate
);

    opcode_e opcode;

    assign opcode = opcode_e'(instruction[6:0]);

    always_comb begin
        case (opcode)
            op_store:
                immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            op_branch:
                immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
            op_lui, op_auipc:
                immediate = {instruction[31:12], 12'b0};
            op_jal:
                immediate = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                             instruction[20], instruction[30:21], 1'b0};
            default:
                immediate = {{20{instruction[31]}}, instruction[31:20]};  // I type
        endcase
    end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    input  logic [4:0]      rd_addr,
    input  logic            write_enable,
    input  logic [xlen-1:0] write_data,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd_addr != 5'd0) begin  // x0 stays zero
            regs[rd_addr] <= write_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

//--- logic/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  opcode_e opcode,
    output ctrl_t   ctrl
);

    state_e state;
    state_e next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = st_fetch;
        case (state)
            st_fetch: next_state = st_decode;
            st_decode: begin
                case (opcode)
                    op_reg:    next_state = st_execute_alu;
                    op_imm:    next_state = st_execute_imm;
                    op_branch: next_state = st_execute_branch;
                    op_jal:    next_state = st_execute_jal;
                    op_jalr:   next_state = st_execute_jalr;
                    op_lui:    next_state = st_execute_lui;
                    op_auipc:  next_state = st_execute_auipc;
                    op_load:   next_state = st_mem_addr;
                    op_store:  next_state = st_mem_addr;
                    default:   next_state = st_fetch;      // Unknown opcode acts as NOP
                endcase
            end
            st_execute_alu:   next_state = st_alu_writeback;
            st_execute_imm:   next_state = st_alu_writeback;
            st_execute_lui:   next_state = st_alu_writeback;
            st_execute_auipc: next_state = st_alu_writeback;
            st_mem_addr:      next_state = (opcode == op_load) ? st_mem_read : st_mem_write;
            st_mem_read:      next_state = st_load_writeback;
            default:          next_state = st_fetch;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.alu_mode = mode_add;
        ctrl.src_a = src_a_rs1;
        ctrl.src_b = src_b_imm;
        ctrl.wb_src = wb_alu;
        case (state)
            st_fetch: begin
                ctrl.mem_read = 1'b1;
                ctrl.ir_write = !reset;
                ctrl.pc_write = 1'b1;
                ctrl.src_a = src_a_pc;
                ctrl.src_b = src_b_four;
            end
            st_decode: begin
                // Branch target, or the link value for jumps
                ctrl.src_a = src_a_old_pc;
                ctrl.src_b = (opcode == op_jal || opcode == op_jalr) ? src_b_four : src_b_imm;
            end
            st_execute_alu: begin
                ctrl.alu_mode = mode_reg;
                ctrl.src_b = src_b_rs2;
            end
            st_execute_imm: ctrl.alu_mode = mode_imm;
            st_execute_branch: begin
                ctrl.alu_mode = mode_branch;
                ctrl.src_b = src_b_rs2;
                ctrl.pc_write_cond = 1'b1;
                ctrl.branch_on_ne = 1'b1;
                ctrl.pc_from_alu_reg = 1'b1;                // Target from decode
            end
            st_execute_jal: begin
                ctrl.src_a = src_a_old_pc;
                ctrl.pc_write = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            st_execute_jalr: begin
                ctrl.pc_write = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            st_execute_lui:   ctrl.src_a = src_a_zero;
            st_execute_auipc: ctrl.src_a = src_a_old_pc;
            st_mem_read: begin
                ctrl.addr_from_alu = 1'b1;
                ctrl.mem_read = 1'b1;
            end
            st_mem_write: begin
                ctrl.addr_from_alu = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            st_load_writeback: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_src = wb_mem;
            end
            st_alu_writeback: ctrl.reg_write = 1'b1;
            default: ;                                      // mem_addr uses the defaults
        endcase
    end

endmodule

`default_nettype wire

//--- logic/core.sv
`timescale 1ns/1ps
`default_nettype none

module core
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [xlen-1:0] read_data,
    output mem_req_t        mem_req
);

    ctrl_t ctrl;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] old_pc;
    logic [xlen-1:0] ir;
    logic [xlen-1:0] mdr;
    logic [xlen-1:0] alu_reg;
    logic [xlen-1:0] rs1_reg;
    logic [xlen-1:0] rs2_reg;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] immediate;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_data;
    logic            zero;
    logic            branch_ne;
    logic            pc_load;

    control_unit u_control (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode_e'(ir[6:0])),
        .ctrl   (ctrl)
    );

    reg_file u_regs (
        .clk          (clk),
        .reset        (reset),
        .rs1_addr     (ir[19:15]),
        .rs2_addr     (ir[24:20]),
        .rd_addr      (ir[11:7]),
        .write_enable (ctrl.reg_write),
        .write_data   (wb_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    imm_gen u_imm (
        .instruction (ir),
        .immediate   (immediate)
    );

    alu u_alu (
        .mode   (ctrl.alu_mode),
        .funct3 (ir[14:12]),
        .funct7 (ir[31:25]),
        .in_a   (alu_a),
        .in_b   (alu_b),
        .result (alu_result),
        .zero   (zero)
    );

    always_comb begin
        case (ctrl.src_a)
            src_a_pc:     alu_a = pc;
            src_a_rs1:    alu_a = rs1_reg;
            src_a_old_pc: alu_a = old_pc;
            default:      alu_a = '0;
        endcase
        case (ctrl.src_b)
            src_b_rs2:  alu_b = rs2_reg;
            src_b_four: alu_b = 32'd4;
            default:    alu_b = immediate;
        endcase
    end

    assign wb_data = (ctrl.wb_src == wb_mem) ? mdr : alu_reg;

    // BNE inverts the sense of the zero flag
    assign branch_ne = ctrl.branch_on_ne & ir[12];
    assign pc_load = ctrl.pc_write | (ctrl.pc_write_cond & (zero != branch_ne));
    assign pc_next = ctrl.pc_from_alu_reg ? alu_reg : {alu_result[xlen-1:1], 1'b0};

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= boot_address;
            ir <= '0;
        end else begin
            if (pc_load) begin
                pc <= pc_next;
            end
            if (ctrl.ir_write) begin
                ir <= read_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            old_pc <= pc;                                  // PC of the fetched instruction
        end
        if (ctrl.mem_read) begin
            mdr <= read_data;
        end
        rs1_reg <= rs1_data;
        rs2_reg <= rs2_data;
        alu_reg <= alu_result;
    end

    assign mem_req.read = ctrl.mem_read;
    assign mem_req.write = ctrl.mem_write;
    assign mem_req.addr = ctrl.addr_from_alu ? alu_reg : pc;
    assign mem_req.wdata = rs2_reg;

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #2 clk = ~clk;                                  // 4 ns period

endmodule

`default_nettype wire

//--- dv/core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module core_assertions
    import core_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input mem_req_t mem_req
);

    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.read && mem_req.write))
        else $error("read and write strobes asserted together");

    no_write_in_reset: assert property (@(posedge clk) reset |-> !mem_req.write)
        else $error("write strobe asserted during reset");

    no_write_after_reset: assert property (@(posedge clk) $fell(reset) |-> !mem_req.write)
        else $error("write strobe asserted in the first cycle after reset");

    write_aligned: assert property (@(posedge clk) disable iff (reset)
        mem_req.write |-> mem_req.addr[1:0] == 2'b00)
        else $error("write address is not word aligned");

endmodule

bind core core_assertions u_assertions (
    .clk     (clk),
    .reset   (reset),
    .mem_req (mem_req)
);

`default_nettype wire

//--- dv/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb
    import core_pkg::*;
();

    localparam logic [31:0] mailbox = 32'h7f0;
    localparam logic [31:0] done_addr = 32'h7fc;
    localparam int budget_reset = 40;
    localparam int budget_alu = 900;
    localparam int budget_mem = 200;
    localparam int budget_flow = 300;
    localparam int budget_timing = 100;
    localparam int watchdog_cycles = budget_reset + budget_alu + budget_mem + budget_flow
                                     + budget_timing + 200;      // Reset and load overhead
    // RV32I op order: add sub sll slt sltu xor srl sra or and
    localparam logic [2:0] op_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    localparam logic       op_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};

    logic        clk;
    logic        reset;
    logic [31:0] read_data;
    mem_req_t    mem_req;
    logic [31:0] mem [1024];
    logic [31:0] rng_state = 32'hc349_e057;
    logic [31:0] prog_addr;
    logic [31:0] write_addr_q [$];
    logic [31:0] write_data_q [$];
    logic [31:0] read_addr_q [$];
    int          read_cycle_q [$];

    tb_clock u_clock (.clk(clk));

    core u_dut (
        .clk       (clk),
        .reset     (reset),
        .read_data (read_data),
        .mem_req   (mem_req)
    );

    assign read_data = mem[mem_req.addr[11:2]];             // Combinational read

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] r_type(input logic [31:0] f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] imm, rs1, f3, rd,
                                           input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input logic [31:0] imm, rs2, rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [31:0] imm, rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
    endfunction

    // Result of an RV32I operation by its index in the op order
    function automatic logic [31:0] rv32_result(input int k, input logic [31:0] a, b);
        case (k)
            0: return a + b;
            1: return a - b;
            2: return a << b[4:0];
            3: return {31'b0, $signed(a) < $signed(b)};
            4: return {31'b0, a < b};
            5: return a ^ b;
            6: return a >> b[4:0];
            7: return 32'($signed(a) >>> b[4:0]);
            8: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic int first_read_cycle(input logic [31:0] addr);
        foreach (read_addr_q[i]) begin
            if (read_addr_q[i] == addr) return read_cycle_q[i];
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual, expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: actual 0x%08h expected 0x%08h", name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (32'(i) * 32'h0001_0003) ^ 32'h6b00_0000;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        mem[prog_addr[11:2]] = word;
        prog_addr = prog_addr + 32'd4;
    endtask

    task automatic load_immediate(input logic [31:0] rd, value);
        emit(u_type((value + 32'h800) >> 12, rd, op_lui));  // Rounds for the ADDI sign
        emit(i_type(value, rd, 0, rd, op_imm));
    endtask

    task automatic store_mailbox(input logic [31:0] rs);
        emit(s_type(mailbox, rs, 0));
    endtask

    task automatic emit_marker(input logic [31:0] value);
        emit(i_type(value, 0, 0, 10, op_imm));
        store_mailbox(10);
    endtask

    task automatic finish_program();
        emit(s_type(done_addr, 0, 0));
        emit(j_type(0, 0));                                 // Spin in place
    endtask

    task automatic start_program();
        @(posedge clk);
        reset <= 1'b1;
        fill_memory();
        prog_addr = boot_address;
        write_addr_q.delete();
        write_data_q.delete();
        read_addr_q.delete();
        read_cycle_q.delete();
    endtask

    task automatic run_program(input int budget);
        logic        done;
        logic        write_pending;
        logic [31:0] write_addr;
        logic [31:0] write_data;
        done = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_value("mem_req.write", 32'(mem_req.write), 0);
            @(posedge clk);
        end
        reset <= 1'b0;
        for (int cycle = 0; cycle < budget && !done; cycle++) begin
            @(negedge clk);
            write_pending = mem_req.write;
            write_addr = mem_req.addr;
            write_data = mem_req.wdata;
            if (mem_req.read) begin
                read_addr_q.push_back(mem_req.addr);
                read_cycle_q.push_back(cycle);
            end
            if (write_pending) begin
                write_addr_q.push_back(write_addr);
                write_data_q.push_back(write_data);
                done = (write_addr == done_addr);
            end
            @(posedge clk);
            if (write_pending) mem[write_addr[11:2]] = write_data;
        end
        if (!done) begin
            fail_run($sformatf("Program did not reach the done store within %0d cycles", budget));
        end
    endtask

    task automatic check_write(input int index, input logic [31:0] addr, data);
        check_value("mem_req.addr", write_addr_q[index], addr);
        check_value("mem_req.wdata", write_data_q[index], data);
    endtask

    task automatic reset_behavior();
        start_program();
        finish_program();
        run_program(budget_reset);
        check_value("first read addr", read_addr_q[0], boot_address);
        check_value("first read cycle", read_cycle_q[0], 0);
        check_value("write count", write_addr_q.size(), 1);
    endtask

    task automatic alu_operations();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] imm_field;
        logic [31:0] expected [$];
        logic        is_shift;
        start_program();
        for (int round = 0; round < 3; round++) begin
            a = xorshift();
            b = xorshift();
            load_immediate(1, a);
            load_immediate(2, b);
            for (int k = 0; k < 10; k++) begin
                emit(r_type(op_alt[k] ? 32'h20 : 32'h0, 2, 1, 32'(op_f3[k]), 3));
                store_mailbox(3);
                expected.push_back(rv32_result(k, a, b));
            end
            for (int k = 0; k < 10; k++) begin
                if (k == 1) continue;                       // No SUBI
                r = xorshift();
                is_shift = (k == 2 || k == 6 || k == 7);
                if (is_shift) begin
                    imm_field = (op_alt[k] ? 32'h400 : 32'h0) | {27'b0, r[4:0]};
                    b = {27'b0, r[4:0]};
                end else begin
                    imm_field = {20'b0, r[11:0]};
                    b = {{20{r[11]}}, r[11:0]};
                end
                emit(i_type(imm_field, 1, 32'(op_f3[k]), 3, op_imm));
                store_mailbox(3);
                expected.push_back(rv32_result(k, a, b));
            end
        end
        finish_program();
        run_program(budget_alu);
        check_value("write count", write_addr_q.size(), expected.size() + 1);
        foreach (expected[i]) check_write(i, mailbox, expected[i]);
    endtask

    task automatic load_store_path();
        logic [31:0] w;
        w = xorshift();
        start_program();
        load_immediate(5, w);
        load_immediate(8, 32'h400);
        emit(s_type(0, 5, 8));
        emit(i_type(0, 8, 2, 6, op_load));
        emit(s_type(8, 6, 8));
        emit(i_type(123, 0, 0, 0, op_imm));                 // Writes to x0 are dropped
        emit(u_type(32'habcde, 0, op_lui));
        emit(r_type(0, 5, 5, 0, 0));
        store_mailbox(0);
        finish_program();
        run_program(budget_mem);
        check_value("write count", write_addr_q.size(), 4);
        check_write(0, 32'h400, w);
        check_write(1, 32'h408, w);
        check_write(2, mailbox, 0);
    endtask

    task automatic control_flow();
        logic [31:0] r;
        logic [31:0] pc_jal;
        logic [31:0] pc_auipc;
        logic [31:0] expected [$];
        r = xorshift();
        start_program();
        load_immediate(1, r);
        load_immediate(2, r);
        load_immediate(3, r ^ 32'h10);
        emit(b_type(12, 3, 1, 0));                          // BEQ not taken
        emit_marker(1);
        emit(b_type(12, 2, 1, 0));                          // BEQ taken
        emit_marker(99);
        emit(b_type(12, 2, 1, 1));                          // BNE not taken
        emit_marker(2);
        emit(b_type(12, 3, 1, 1));                          // BNE taken
        emit_marker(99);
        emit_marker(3);
        pc_jal = prog_addr;
        emit(j_type(12, 11));
        emit_marker(99);
        store_mailbox(11);
        emit_marker(4);
        pc_auipc = prog_addr;
        emit(u_type(0, 12, op_auipc));
        emit(i_type(17, 12, 0, 13, op_jalr));               // Odd target, bit 0 cleared
        emit_marker(99);
        store_mailbox(13);
        emit_marker(5);
        finish_program();
        run_program(budget_flow);
        expected = '{1, 2, 3, pc_jal + 4, 4, pc_auipc + 8, 5};
        check_value("write count", write_addr_q.size(), expected.size() + 1);
        foreach (expected[i]) check_write(i, mailbox, expected[i]);
        foreach (read_addr_q[i]) begin
            check_value("mem_req.addr[1:0]", read_addr_q[i] & 32'h3, 0);
        end
    endtask

    task automatic instruction_timing();
        int c [5];
        start_program();
        emit(b_type(4, 0, 0, 0));
        emit(i_type(5, 0, 0, 1, op_imm));
        emit(s_type(32'h400, 1, 0));
        emit(i_type(32'h400, 0, 2, 2, op_load));
        store_mailbox(2);
        finish_program();
        run_program(budget_timing);
        for (int i = 0; i < 5; i++) c[i] = first_read_cycle(32'(i * 4));
        check_value("branch cycles", c[1] - c[0], 3);
        check_value("alu cycles", c[2] - c[1], 4);
        check_value("store cycles", c[3] - c[2], 4);
        check_value("load cycles", c[4] - c[3], 5);
        check_write(1, mailbox, 5);
    endtask

    initial begin
        #(watchdog_cycles * 4);
        $display("Watchdog expired after %0d cycles", watchdog_cycles);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        reset = 1'b1;
        fill_memory();
        reset_behavior();
        alu_operations();
        load_store_path();
        control_flow();
        instruction_timing();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
logic/core_pkg.sv
logic/alu.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/control_unit.sv
logic/core.sv
dv/tb_clock.sv
dv/core_assertions.sv
dv/core_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := core_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(shell grep '\.sv$$' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
